// File: Makefile
TOP := femto8_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -o femto8_sim -f vlog.f
	@out="$$(./obj_dir/femto8_sim)"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import femto8_pkg::*; #(
	parameter int WIDTH = DATA_W
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             carry,
	input  alu_op_t          op,
	output logic [WIDTH:0]   y
);

	logic [WIDTH:0] a_ext;
	logic [WIDTH:0] b_ext;
	logic [WIDTH:0] c_ext;

	// zero extended so the top bit catches carry or borrow
	assign a_ext = {1'b0, a};
	assign b_ext = {1'b0, b};
	assign c_ext = {{WIDTH{1'b0}}, carry};

	always_comb begin
		case (op)
			OP_ZERO:   y = '0;
			OP_LOAD_A: y = a_ext;
			OP_INC:    y = a_ext + 1'b1;
			OP_DEC:    y = a_ext - 1'b1;
			// shifted out bit lands in y[WIDTH]
			OP_ASL:    y = {a, 1'b0};
			OP_LSR:    y = {a[0], 1'b0, a[WIDTH-1:1]};
			OP_ROL:    y = {a, carry};
			OP_ROR:    y = {a[0], carry, a[WIDTH-1:1]};
			OP_OR:     y = {1'b0, a | b};
			OP_AND:    y = {1'b0, a & b};
			OP_XOR:    y = {1'b0, a ^ b};
			OP_LOAD_B: y = b_ext;
			OP_ADD:    y = a_ext + b_ext;
			OP_SUB:    y = a_ext - b_ext;
			OP_ADC:    y = a_ext + b_ext + c_ext;
			OP_SBB:    y = a_ext - b_ext - c_ext;
			default:   y = '0;
		endcase
	end

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import femto8_pkg::*; (
	mem_bus_if.arbiter        core_bus,
	mem_bus_if.arbiter        host_bus,
	input  logic              host_req,
	output logic [DATA_W-1:0] mem_address,
	output logic [DATA_W-1:0] mem_wdata,
	output logic              mem_write,
	input  logic [DATA_W-1:0] mem_rdata
);

	// host always wins and the core gets every cycle the host leaves idle
	assign host_bus.grant = host_req;
	assign core_bus.grant = ~host_req;

	always_comb begin
		if (host_bus.grant) begin
			mem_address = host_bus.address;
			mem_wdata   = host_bus.wdata;
		end else begin
			mem_address = core_bus.address;
			mem_wdata   = core_bus.wdata;
		end
	end

	// strobe of the losing side never reaches memory
	assign mem_write = (host_bus.grant & host_bus.write) |
		(core_bus.grant & core_bus.write);

	// only the granted side's address is on the array, so both see that word
	assign host_bus.rdata = mem_rdata;
	assign core_bus.rdata = mem_rdata;

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import femto8_pkg::*; (
	input logic          clk,
	input logic          reset,
	mem_bus_if.requester bus
);

	cpu_state_t        state;
	logic [DATA_W-1:0] ip;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] opcode;
	logic [DATA_W-1:0] address;
	logic [DATA_W-1:0] wdata;
	logic              store_pulse;
	logic              carry;
	logic              zero;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W:0]   y;
	alu_op_t           alu_op;
	dest_t             dest;
	logic              branch_taken;

	assign alu_op = alu_op_t'(opcode[3:0]);
	assign dest   = dest_t'(opcode[5:4]);

	// bit 6 picks immediate or [B] over register B
	assign alu_b = opcode[6] ? bus.rdata : b;

	// flag test on the opcode byte while in decode
	assign branch_taken = (bus.rdata[0] && (bus.rdata[1] == carry)) ||
		(bus.rdata[2] && (bus.rdata[3] == zero));

	assign bus.address = address;
	assign bus.wdata   = wdata;
	// a pending store waits out a lost grant
	assign bus.write   = store_pulse & bus.grant;

	alu #(
		.WIDTH(DATA_W)
	) u_alu (
		.a    (a),
		.b    (alu_b),
		.carry(carry),
		.op   (alu_op),
		.y    (y)
	);

	// sequencer, one step per granted edge
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= S_RESET;
			store_pulse <= 1'b0;
		end else if (bus.grant) begin
			store_pulse <= 1'b0;
			case (state)
				S_RESET:  state <= S_SELECT;
				S_SELECT: state <= S_DECODE;
				S_DECODE: begin
					casez (bus.rdata)
						8'b00??????, 8'b01??????, 8'b11??????: state <= S_COMPUTE;
						8'b1001????: begin
							store_pulse <= 1'b1;
							state       <= S_SELECT;
						end
						8'b10000001, 8'b10001000: state <= S_SELECT;
						8'b1010????: state <= branch_taken ? S_READ_IP : S_SELECT;
						// unknown opcodes restart the core
						default: state <= S_RESET;
					endcase
				end
				S_COMPUTE, S_READ_IP: state <= S_SELECT;
				default: state <= S_RESET;
			endcase
		end
	end

	// registers, flags and bus address
	always_ff @(posedge clk) begin
		if (bus.grant) begin
			case (state)
				S_RESET: begin
					ip      <= RESET_IP;
					address <= RESET_IP;
				end
				S_SELECT: begin
					address <= ip;
					ip      <= ip + 1'b1;
				end
				S_DECODE: begin
					opcode <= bus.rdata;
					casez (bus.rdata)
						// immediate follows the opcode
						8'b01??????: begin
							address <= ip;
							ip      <= ip + 1'b1;
						end
						8'b11??????: address <= b;
						8'b1001????: begin
							address <= {4'b0000, bus.rdata[3:0]};
							wdata   <= a;
						end
						8'b10000001: begin
							a <= b;
							b <= a;
						end
						8'b10001000: carry <= 1'b0;
						8'b1010????: begin
							if (branch_taken)
								address <= ip;
							// target byte skipped either way
							ip <= ip + 1'b1;
						end
						default: ;
					endcase
				end
				S_COMPUTE: begin
					case (dest)
						DEST_A:  a  <= y[DATA_W-1:0];
						DEST_B:  b  <= y[DATA_W-1:0];
						DEST_IP: ip <= y[DATA_W-1:0];
						default: ;
					endcase
					// shifts and arithmetic with carry, ops 4-7 and 12-15
					if (opcode[2])
						carry <= y[DATA_W];
					zero <= ~|y[DATA_W-1:0];
				end
				S_READ_IP: ip <= bus.rdata;
				default: ;
			endcase
		end
	end

endmodule

// File: logic/femto8_pkg.sv
package femto8_pkg;

	// one word for data, addresses and instructions
	localparam int DATA_W = 8;

	// program half of memory starts here
	localparam logic [DATA_W-1:0] RESET_IP = 8'h80;

	// alu operations, low nibble of a compute opcode
	// carry is written back only when bit 2 is set
	typedef enum logic [3:0] {
		OP_ZERO   = 4'h0,
		OP_LOAD_A = 4'h1,
		OP_INC    = 4'h2,
		OP_DEC    = 4'h3,
		OP_ASL    = 4'h4,
		OP_LSR    = 4'h5,
		OP_ROL    = 4'h6,
		OP_ROR    = 4'h7,
		OP_OR     = 4'h8,
		OP_AND    = 4'h9,
		OP_XOR    = 4'ha,
		OP_LOAD_B = 4'hb,
		OP_ADD    = 4'hc,
		OP_SUB    = 4'hd,
		OP_ADC    = 4'he,
		OP_SBB    = 4'hf
	} alu_op_t;

	// compute destination, bits 5:4 of a compute opcode
	typedef enum logic [1:0] {
		DEST_A    = 2'b00,
		DEST_B    = 2'b01,
		DEST_IP   = 2'b10,
		DEST_NONE = 2'b11
	} dest_t;

	// core sequencer states
	typedef enum logic [2:0] {
		S_RESET   = 3'd0,
		S_SELECT  = 3'd1,
		S_DECODE  = 3'd2,
		S_COMPUTE = 3'd3,
		S_READ_IP = 3'd4
	} cpu_state_t;

endpackage

// File: logic/femto8_top.sv
`timescale 1ns/1ps

module femto8_top import femto8_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              host_req,
	input  logic              host_write,
	input  logic [DATA_W-1:0] host_address,
	input  logic [DATA_W-1:0] host_wdata,
	output logic [DATA_W-1:0] host_rdata
);

	logic [DATA_W-1:0] mem_address;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] mem_rdata;
	logic              mem_write;

	mem_bus_if core_bus ();
	mem_bus_if host_bus ();

	// host side of the arbiter from plain ports
	assign host_bus.address = host_address;
	assign host_bus.wdata   = host_wdata;
	assign host_bus.write   = host_write;
	assign host_rdata       = host_bus.rdata;

	cpu_core u_core (
		.clk  (clk),
		.reset(reset),
		.bus  (core_bus)
	);

	bus_arbiter u_arbiter (
		.core_bus   (core_bus),
		.host_bus   (host_bus),
		.host_req   (host_req),
		.mem_address(mem_address),
		.mem_wdata  (mem_wdata),
		.mem_write  (mem_write),
		.mem_rdata  (mem_rdata)
	);

	memory u_memory (
		.clk    (clk),
		.address(mem_address),
		.wdata  (mem_wdata),
		.write  (mem_write),
		.rdata  (mem_rdata)
	);

endmodule

// File: logic/mem_bus_if.sv
`timescale 1ns/1ps

// one requester's view of the shared memory
interface mem_bus_if import femto8_pkg::*; ();

	logic [DATA_W-1:0] address;
	logic [DATA_W-1:0] wdata;
	logic              write;
	logic [DATA_W-1:0] rdata;
	logic              grant;

	// write may only be raised while grant is high
	modport requester (
		output address,
		output wdata,
		output write,
		input  rdata,
		input  grant
	);

	modport arbiter (
		input  address,
		input  wdata,
		input  write,
		output rdata,
		output grant
	);

endinterface

// File: logic/memory.sv
`timescale 1ns/1ps

module memory import femto8_pkg::*; (
	input  logic              clk,
	input  logic [DATA_W-1:0] address,
	input  logic [DATA_W-1:0] wdata,
	input  logic              write,
	output logic [DATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << DATA_W;

	// low half data, high half program, one array
	logic [DATA_W-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (write)
			mem[address] <= wdata;
	end

	// asynchronous read
	assign rdata = mem[address];

endmodule

// File: tests/femto8_checker.sv
`timescale 1ns/1ps

module femto8_checker import femto8_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       write,
	input logic       grant,
	input cpu_state_t state
);

	// store strobe only in the fetch slot that follows a store decode
	a_write_in_select: assert property (@(posedge clk) write |-> state == S_SELECT)
		else $error("core write outside the select state");

	// store pulse is one cycle wide
	a_write_single: assert property (@(posedge clk) disable iff (reset) write |=> !write)
		else $error("core write held longer than one cycle");

	a_write_after_reset: assert property (@(posedge clk) reset |=> !write)
		else $error("core write in the cycle after reset");

	// frozen while the host holds the bus
	a_state_hold: assert property (@(posedge clk) disable iff (reset)
		!grant |=> $stable(state))
		else $error("core state moved without grant");

endmodule

bind cpu_core femto8_checker u_checker (
	.clk  (clk),
	.reset(reset),
	.write(bus.write),
	.grant(bus.grant),
	.state(state)
);

// File: tests/femto8_tb.sv
`timescale 1ns/1ps

module femto8_tb import femto8_pkg::*; ();

	localparam logic [7:0] SENTINEL    = 8'ha5;
	localparam logic [7:0] RESULT_ADDR = 8'h0f;

	logic       clk;
	logic       reset;
	logic       host_req;
	logic       host_write;
	logic [7:0] host_address;
	logic [7:0] host_wdata;
	logic [7:0] host_rdata;

	logic [31:0] lfsr;
	logic [7:0]  prog [$];
	int          errors;
	int          checks;

	femto8_top UUT (
		.clk         (clk),
		.reset       (reset),
		.host_req    (host_req),
		.host_write  (host_write),
		.host_address(host_address),
		.host_wdata  (host_wdata),
		.host_rdata  (host_rdata)
	);

	always #20 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		logic       fb;
		int         i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[6:0], fb};
		end
		return r;
	endfunction

	// expected nine bit result with carry or borrow on top
	function automatic logic [8:0] alu_model(input alu_op_t op, input logic [7:0] a,
		input logic [7:0] b, input logic c);
		int ai;
		int bi;
		int ci;
		int r;
		ai = int'(a);
		bi = int'(b);
		ci = int'(c);
		case (op)
			OP_ZERO:   r = 0;
			OP_LOAD_A: r = ai;
			OP_INC:    r = ai + 1;
			OP_DEC:    r = ai - 1;
			OP_ASL:    r = ai * 2;
			OP_LSR:    r = ai / 2 + (ai % 2) * 256;
			OP_ROL:    r = ai * 2 + ci;
			OP_ROR:    r = ai / 2 + ci * 128 + (ai % 2) * 256;
			OP_OR:     r = ai | bi;
			OP_AND:    r = ai & bi;
			OP_XOR:    r = ai ^ bi;
			OP_LOAD_B: r = bi;
			OP_ADD:    r = ai + bi;
			OP_SUB:    r = ai - bi;
			OP_ADC:    r = ai + bi + ci;
			OP_SBB:    r = ai - bi - ci;
			default:   r = 0;
		endcase
		return 9'(r);
	endfunction

	function automatic logic [7:0] fib_last_below_256();
		int x;
		int y;
		int t;
		x = 1;
		y = 1;
		while (x + y < 256) begin
			t = x + y;
			x = y;
			y = t;
		end
		return 8'(y);
	endfunction

	task automatic host_write_byte(input logic [7:0] addr, input logic [7:0] data);
		host_req     = 1'b1;
		host_write   = 1'b1;
		host_address = addr;
		host_wdata   = data;
		@(posedge clk);
		#2;
		host_write = 1'b0;
	endtask

	task automatic host_read_check(input logic [7:0] addr, input logic [7:0] exp,
		input string name);
		host_req     = 1'b1;
		host_write   = 1'b0;
		host_address = addr;
		@(negedge clk);
		checks++;
		if (host_rdata !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: host_rdata (%s, addr %02h) expected %02h, actual %02h",
				$time, name, addr, exp, host_rdata);
		end
		@(posedge clk);
		#2;
	endtask

	// core sits in reset while the host owns the bus
	task automatic load_program();
		int i;
		host_req = 1'b1;
		reset    = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		for (i = 0; i < 16; i++)
			host_write_byte(8'(i), 8'h00);
		for (i = 0; i < prog.size(); i++)
			host_write_byte(8'h80 + 8'(i), prog[i]);
	endtask

	// busy mode grabs the bus for random stretches
	task automatic wait_for_result(input logic busy);
		int   cycles;
		int   gap;
		int   hold;
		logic done;
		cycles = 0;
		done   = 1'b0;
		while (!done && cycles < 2000) begin
			gap      = busy ? 1 + int'(rand_bits(3)) : 8;
			hold     = busy ? 1 + int'(rand_bits(3)) : 1;
			host_req = 1'b0;
			repeat (gap) @(posedge clk);
			#2;
			host_req     = 1'b1;
			host_address = RESULT_ADDR;
			repeat (hold - 1) @(posedge clk);
			@(negedge clk);
			done = (host_rdata === SENTINEL);
			@(posedge clk);
			#2;
			cycles += gap + hold;
		end
		if (!done) begin
			errors++;
			$display("timeout: program did not store its sentinel within 2000 cycles");
		end
	endtask

	function automatic void emit_pair(input logic [7:0] opcode, input logic [7:0] arg);
		prog.push_back(opcode);
		prog.push_back(arg);
	endfunction

	// 0xff + 1 sets carry, clear-carry drops it
	function automatic void emit_carry_setup(input logic c);
		if (c) begin
			emit_pair(8'h4b, 8'hff);
			emit_pair(8'h4c, 8'h01);
		end else begin
			prog.push_back(8'h88);
		end
	endfunction

	// sentinel store and a jump to self take 5 bytes
	function automatic void emit_finish();
		logic [7:0] here;
		emit_pair(8'h4b, SENTINEL);
		prog.push_back(8'h90 | RESULT_ADDR);
		here = 8'h80 + 8'(prog.size());
		emit_pair(8'h6b, here);
	endfunction

	task automatic check_memory_round_trip();
		logic [7:0] expect_mem [256];
		int         i;
		for (i = 0; i < 256; i++) begin
			expect_mem[i] = rand_bits(8);
			host_write_byte(8'(i), expect_mem[i]);
		end
		for (i = 0; i < 256; i++)
			host_read_check(8'(i), expect_mem[i], "memory word");
	endtask

	task automatic run_alu_case(input alu_op_t op, input logic cin);
		logic [7:0] ra;
		logic [7:0] rb;
		logic [8:0] y;
		logic       cout;
		ra   = rand_bits(8);
		rb   = rand_bits(8);
		y    = alu_model(op, ra, rb, cin);
		cout = op[2] ? y[8] : cin;
		prog.delete();
		emit_carry_setup(cin);
		emit_pair(8'h4b, ra);
		emit_pair({4'h4, op}, rb);
		prog.push_back(8'h90);
		// A cleared, then 0 + 0 + carry gives the marker
		prog.push_back(8'h00);
		emit_pair(8'h4e, 8'h00);
		prog.push_back(8'h91);
		emit_finish();
		load_program();
		wait_for_result(1'b0);
		host_read_check(8'h00, y[7:0], "alu result");
		host_read_check(8'h01, {7'b0, cout}, "carry marker");
	endtask

	task automatic check_swap_and_memory_operand();
		logic [7:0] r1;
		logic [7:0] r2;
		logic [7:0] sum;
		r1  = rand_bits(8);
		r2  = rand_bits(8);
		sum = r1 + r2;
		prog.delete();
		// B = 0x20 through destination B
		emit_pair(8'h5b, 8'h20);
		emit_pair(8'h4b, r2);
		// A = A + [B], store, swap, store, A = A - B, store
		prog.push_back(8'hcc);
		prog.push_back(8'h90);
		prog.push_back(8'h81);
		prog.push_back(8'h91);
		prog.push_back(8'h0d);
		prog.push_back(8'h92);
		emit_finish();
		load_program();
		host_write_byte(8'h20, r1);
		wait_for_result(1'b0);
		host_read_check(8'h00, sum, "a plus mem at b");
		host_read_check(8'h01, 8'h20, "a after swap");
		host_read_check(8'h02, 8'h20 - sum, "a minus b");
	endtask

	task automatic check_branch_case(input logic [3:0] cond, input logic c, input logic z);
		logic       taken;
		logic [7:0] target;
		taken = (cond[0] && cond[1] == c) || (cond[2] && cond[3] == z);
		prog.delete();
		emit_carry_setup(c);
		// loading leaves carry alone and sets zero
		emit_pair(8'h4b, z ? 8'h00 : 8'h01);
		// skip the branch and the 8 byte fall-through block
		target = 8'h80 + 8'(prog.size()) + 8'd10;
		emit_pair({4'ha, cond}, target);
		emit_pair(8'h4b, 8'h22);
		prog.push_back(8'h90);
		emit_finish();
		emit_pair(8'h4b, 8'h11);
		prog.push_back(8'h90);
		emit_finish();
		load_program();
		wait_for_result(1'b0);
		host_read_check(8'h00, taken ? 8'h11 : 8'h22, "branch marker");
	endtask

	task automatic run_fibonacci(input logic busy);
		prog.delete();
		emit_pair(8'h4b, 8'h00);
		emit_pair(8'h5b, 8'h01);
		// loop at 0x84 leaves on carry
		prog.push_back(8'h0c);
		emit_pair(8'ha3, 8'h8a);
		prog.push_back(8'h81);
		emit_pair(8'h6b, 8'h84);
		// last term below 256 is still in B here
		prog.push_back(8'h81);
		prog.push_back(8'h90);
		emit_pair(8'h4b, SENTINEL);
		prog.push_back(8'h90 | RESULT_ADDR);
		prog.push_back(8'h80);
		load_program();
		wait_for_result(busy);
		host_read_check(8'h00, fib_last_below_256(), "fibonacci result");
	endtask

	initial begin
		int opi;
		int ci;
		int zi;
		int cond;
		lfsr         = 32'h2e209e3e;
		errors       = 0;
		checks       = 0;
		clk          = 1'b0;
		reset        = 1'b1;
		host_req     = 1'b1;
		host_write   = 1'b0;
		host_address = 8'h00;
		host_wdata   = 8'h00;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		check_memory_round_trip();
		for (opi = 0; opi < 16; opi++)
			for (ci = 0; ci < 2; ci++)
				run_alu_case(alu_op_t'(opi[3:0]), ci[0]);
		check_swap_and_memory_operand();
		for (cond = 0; cond < 16; cond++)
			for (ci = 0; ci < 2; ci++)
				for (zi = 0; zi < 2; zi++)
					check_branch_case(cond[3:0], ci[0], zi[0]);
		run_fibonacci(1'b0);
		run_fibonacci(1'b1);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: vlog.f
logic/femto8_pkg.sv
logic/mem_bus_if.sv
logic/alu.sv
logic/cpu_core.sv
logic/bus_arbiter.sv
logic/memory.sv
logic/femto8_top.sv
tests/femto8_checker.sv
tests/femto8_tb.sv
